// ==== rtl/soc_pkg.sv ====
// Bus types, response codes and address map shared by every block of the SoC bus, compiled first
package soc_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [1:0] resp_t;
	// One pad, 1 = pressed, bit 0 shifted in first
	typedef logic [7:0] buttons_t;

	localparam resp_t resp_okay = 2'd0;
	localparam resp_t resp_slverr = 2'd2;
	localparam resp_t resp_decerr = 2'd3;

	// Master to slave
	typedef struct packed {
		logic awvalid;
		addr_t awaddr;
		logic wvalid;
		data_t wdata;
		strb_t wstrb;
		logic bready;
		logic arvalid;
		addr_t araddr;
		logic rready;
	} axil_req_t;

	// Slave to master
	typedef struct packed {
		logic awready;
		logic wready;
		logic bvalid;
		resp_t bresp;
		logic arready;
		logic rvalid;
		data_t rdata;
		resp_t rresp;
	} axil_rsp_t;

	localparam addr_t boot_base = 32'h0201_0000;
	localparam int boot_window_bits = 16;
	localparam addr_t pad_base = 32'h0200_0200;
	localparam int pad_window_bits = 8;
	localparam addr_t counter_base = 32'h0200_0300;
	localparam int counter_window_bits = 8;

	// Register offsets inside the 8-bit pad and counter windows
	localparam logic [7:0] pad_ctrl_offs = 8'h00;
	localparam logic [7:0] pad_state_offs = 8'h04;
	localparam logic [7:0] count_lo_offs = 8'h00;
	localparam logic [7:0] count_hi_offs = 8'h04;

endpackage

// ==== rtl/axil_decoder.sv ====
// One-master AXI-lite decoder: routes each transaction by address window, answers unmapped ones
`timescale 1ns/100ps

module axil_decoder (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_req_t up_req,
	output soc_pkg::axil_rsp_t up_rsp,
	output soc_pkg::axil_req_t boot_req,
	input soc_pkg::axil_rsp_t boot_rsp,
	output soc_pkg::axil_req_t pad_req,
	input soc_pkg::axil_rsp_t pad_rsp,
	output soc_pkg::axil_req_t counter_req,
	input soc_pkg::axil_rsp_t counter_rsp
);

	typedef enum logic [1:0] {st_idle, st_read, st_write, st_error} state_t;

	state_t state;
	logic fwd_valid;
	logic read_q;
	logic [2:0] hit;
	logic [2:0] hit_q;
	logic take_read;
	logic take_write;
	logic slave_hs;
	logic rsp_done;
	soc_pkg::addr_t up_addr;
	soc_pkg::addr_t addr_q;
	soc_pkg::data_t wdata_q;
	soc_pkg::strb_t wstrb_q;
	soc_pkg::axil_req_t fwd;
	soc_pkg::axil_rsp_t sel_rsp;

	function automatic logic in_window(soc_pkg::addr_t addr, soc_pkg::addr_t base, int bits);
		return (addr >> bits) == (base >> bits);
	endfunction

	// Keep payload, drop valid and ready for slaves that are not selected
	function automatic soc_pkg::axil_req_t route(soc_pkg::axil_req_t req, logic en);
		req.awvalid = req.awvalid & en;
		req.wvalid = req.wvalid & en;
		req.bready = req.bready & en;
		req.arvalid = req.arvalid & en;
		req.rready = req.rready & en;
		return req;
	endfunction

	// Reads win when both wait
	assign take_read = (state == st_idle) && up_req.arvalid;
	assign take_write = (state == st_idle) && !up_req.arvalid && up_req.awvalid && up_req.wvalid;
	assign up_addr = up_req.arvalid ? up_req.araddr : up_req.awaddr;

	assign hit = {in_window(up_addr, soc_pkg::counter_base, soc_pkg::counter_window_bits),
		in_window(up_addr, soc_pkg::pad_base, soc_pkg::pad_window_bits),
		in_window(up_addr, soc_pkg::boot_base, soc_pkg::boot_window_bits)};

	always_comb begin
		sel_rsp = boot_rsp;
		if (hit_q[1])
			sel_rsp = pad_rsp;
		else if (hit_q[2])
			sel_rsp = counter_rsp;
	end

	assign slave_hs = fwd_valid &&
		((state == st_read) ? sel_rsp.arready : (sel_rsp.awready && sel_rsp.wready));

	always_comb begin
		case (state)
			st_read: rsp_done = sel_rsp.rvalid && up_req.rready;
			st_write: rsp_done = sel_rsp.bvalid && up_req.bready;
			st_error: rsp_done = read_q ? up_req.rready : up_req.bready;
			default: rsp_done = 1'b0;
		endcase
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			state <= st_idle;
			fwd_valid <= 1'b0;
			read_q <= 1'b0;
			hit_q <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (take_read || take_write) begin
						hit_q <= hit;
						read_q <= take_read;
						if (hit == 3'b000) begin
							state <= st_error;
						end else begin
							state <= take_read ? st_read : st_write;
							fwd_valid <= 1'b1;
						end
					end
				end
				st_read, st_write: begin
					if (slave_hs)
						fwd_valid <= 1'b0;
					if (rsp_done)
						state <= st_idle;
				end
				default: begin
					if (rsp_done)
						state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (take_read || take_write) begin
			addr_q <= up_addr;
			wdata_q <= up_req.wdata;
			wstrb_q <= up_req.wstrb;
		end
	end

	always_comb begin
		fwd = '0;
		fwd.awaddr = addr_q;
		fwd.araddr = addr_q;
		fwd.wdata = wdata_q;
		fwd.wstrb = wstrb_q;
		fwd.arvalid = fwd_valid && (state == st_read);
		fwd.awvalid = fwd_valid && (state == st_write);
		fwd.wvalid = fwd_valid && (state == st_write);
		fwd.rready = (state == st_read) && up_req.rready;
		fwd.bready = (state == st_write) && up_req.bready;
	end

	assign boot_req = route(fwd, hit_q[0]);
	assign pad_req = route(fwd, hit_q[1]);
	assign counter_req = route(fwd, hit_q[2]);

	always_comb begin
		up_rsp = '0;
		up_rsp.arready = (state == st_idle);
		up_rsp.awready = take_write;
		up_rsp.wready = take_write;
		case (state)
			st_read: begin
				up_rsp.rvalid = sel_rsp.rvalid;
				up_rsp.rdata = sel_rsp.rdata;
				up_rsp.rresp = sel_rsp.rresp;
			end
			st_write: begin
				up_rsp.bvalid = sel_rsp.bvalid;
				up_rsp.bresp = sel_rsp.bresp;
			end
			st_error: begin
				// Read data stays zero
				up_rsp.rvalid = read_q;
				up_rsp.rresp = soc_pkg::resp_decerr;
				up_rsp.bvalid = !read_q;
				up_rsp.bresp = soc_pkg::resp_decerr;
			end
			default: ;
		endcase
	end

endmodule

// ==== rtl/boot_ram.sv ====
// Bootloader RAM as an AXI-lite slave with byte strobes, word index wraps modulo boot_words
`timescale 1ns/100ps

module boot_ram #(
	parameter int boot_words = 1024
) (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_req_t bus_req,
	output soc_pkg::axil_rsp_t bus_rsp
);

	// boot_words is a power of two, so slicing gives the wrap
	localparam int idx_bits = $clog2(boot_words);

	soc_pkg::data_t mem [boot_words];
	soc_pkg::data_t rdata_q;
	logic [idx_bits-1:0] rd_idx;
	logic [idx_bits-1:0] wr_idx;
	logic rvalid_q;
	logic bvalid_q;
	logic busy;
	logic rd_hs;
	logic wr_hs;

	assign busy = rvalid_q || bvalid_q;
	assign rd_hs = bus_req.arvalid && !busy;
	assign wr_hs = bus_req.awvalid && bus_req.wvalid && !bus_req.arvalid && !busy;
	assign rd_idx = bus_req.araddr[idx_bits+1:2];
	assign wr_idx = bus_req.awaddr[idx_bits+1:2];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (rd_hs)
				rvalid_q <= 1'b1;
			else if (bus_req.rready)
				rvalid_q <= 1'b0;
			if (wr_hs)
				bvalid_q <= 1'b1;
			else if (bus_req.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_hs)
			rdata_q <= mem[rd_idx];
		if (wr_hs) begin
			for (int b = 0; b < 4; b++) begin
				if (bus_req.wstrb[b])
					mem[wr_idx][8*b +: 8] <= bus_req.wdata[8*b +: 8];
			end
		end
	end

	assign bus_rsp = '{
		awready: wr_hs,
		wready: wr_hs,
		bvalid: bvalid_q,
		bresp: soc_pkg::resp_okay,
		arready: !busy,
		rvalid: rvalid_q,
		rdata: rdata_q,
		rresp: soc_pkg::resp_okay
	};

endmodule

// ==== rtl/tick_counter.sv ====
// Free-running 64-bit system tick counter, read low word first to snapshot the high word
`timescale 1ns/100ps

module tick_counter (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_req_t bus_req,
	output soc_pkg::axil_rsp_t bus_rsp
);

	logic [63:0] count_q;
	soc_pkg::data_t hi_snap_q;
	soc_pkg::data_t rdata_q;
	soc_pkg::resp_t rresp_q;
	logic [7:0] rd_offs;
	logic rvalid_q;
	logic bvalid_q;
	logic busy;
	logic rd_hs;
	logic wr_hs;

	assign busy = rvalid_q || bvalid_q;
	assign rd_hs = bus_req.arvalid && !busy;
	assign wr_hs = bus_req.awvalid && bus_req.wvalid && !bus_req.arvalid && !busy;
	assign rd_offs = bus_req.araddr[soc_pkg::counter_window_bits-1:0];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			count_q <= '0;
			hi_snap_q <= '0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			count_q <= count_q + 64'd1;
			if (rd_hs && rd_offs == soc_pkg::count_lo_offs)
				hi_snap_q <= count_q[63:32];
			if (rd_hs)
				rvalid_q <= 1'b1;
			else if (bus_req.rready)
				rvalid_q <= 1'b0;
			if (wr_hs)
				bvalid_q <= 1'b1;
			else if (bus_req.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_hs) begin
			rdata_q <= '0;
			rresp_q <= soc_pkg::resp_okay;
			if (rd_offs == soc_pkg::count_lo_offs)
				rdata_q <= count_q[31:0];
			else if (rd_offs == soc_pkg::count_hi_offs)
				rdata_q <= hi_snap_q;
			else
				rresp_q <= soc_pkg::resp_slverr;
		end
	end

	// Counter is read-only
	assign bus_rsp = '{
		awready: wr_hs,
		wready: wr_hs,
		bvalid: bvalid_q,
		bresp: soc_pkg::resp_slverr,
		arready: !busy,
		rvalid: rvalid_q,
		rdata: rdata_q,
		rresp: rresp_q
	};

endmodule

// ==== rtl/pad_reader.sv ====
// Serial game pad reader: latches both pads, then clocks in eight buttons from each per frame
`timescale 1ns/100ps

module pad_reader #(
	parameter int pad_div = 256
) (
	input logic clk_50mhz,
	input logic resetn,
	input logic poll_enable,
	output logic pad_latch,
	output logic pad_clk,
	input logic pad0_data,
	input logic pad1_data,
	output soc_pkg::buttons_t pad0_state,
	output soc_pkg::buttons_t pad1_state,
	output logic frame_done
);

	localparam int div_bits = (pad_div > 1) ? $clog2(pad_div) : 1;

	typedef enum logic [1:0] {st_idle, st_latch, st_low, st_high} state_t;

	state_t state;
	logic [div_bits-1:0] div_cnt;
	logic [2:0] bit_cnt;
	logic tick;
	logic sample;
	logic frame_end;
	soc_pkg::buttons_t shift0;
	soc_pkg::buttons_t shift1;

	assign tick = (div_cnt == div_bits'(pad_div - 1));
	// Data is sampled at the end of the low half, before pad_clk rises
	assign sample = tick && (state == st_low);
	assign frame_end = tick && (state == st_high) && (bit_cnt == 3'd7);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			div_cnt <= '0;
			state <= st_idle;
			bit_cnt <= '0;
			pad_latch <= 1'b0;
			pad_clk <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				case (state)
					st_idle: begin
						if (poll_enable) begin
							pad_latch <= 1'b1;
							state <= st_latch;
						end
					end
					st_latch: begin
						pad_latch <= 1'b0;
						bit_cnt <= '0;
						state <= st_low;
					end
					st_low: begin
						pad_clk <= 1'b1;
						state <= st_high;
					end
					default: begin
						pad_clk <= 1'b0;
						bit_cnt <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							frame_done <= 1'b1;
							// Back-to-back frames while polling
							if (poll_enable) begin
								pad_latch <= 1'b1;
								state <= st_latch;
							end else begin
								state <= st_idle;
							end
						end else begin
							state <= st_low;
						end
					end
				endcase
			end
		end
	end

	// Pads drive active low, first bit ends up in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (sample) begin
			shift0 <= {~pad0_data, shift0[7:1]};
			shift1 <= {~pad1_data, shift1[7:1]};
		end
		if (frame_end) begin
			pad0_state <= shift0;
			pad1_state <= shift1;
		end
	end

endmodule

// ==== rtl/pad_regs.sv ====
// AXI-lite registers of the pad reader: poll enable control and the latched button states
`timescale 1ns/100ps

module pad_regs (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_req_t bus_req,
	output soc_pkg::axil_rsp_t bus_rsp,
	output logic poll_enable,
	input soc_pkg::buttons_t pad0_state,
	input soc_pkg::buttons_t pad1_state,
	input logic frame_done
);

	logic [15:0] state_q;
	logic [7:0] rd_offs;
	logic [7:0] wr_offs;
	soc_pkg::data_t rdata_q;
	soc_pkg::resp_t rresp_q;
	soc_pkg::resp_t bresp_q;
	logic rvalid_q;
	logic bvalid_q;
	logic busy;
	logic rd_hs;
	logic wr_hs;

	assign busy = rvalid_q || bvalid_q;
	assign rd_hs = bus_req.arvalid && !busy;
	assign wr_hs = bus_req.awvalid && bus_req.wvalid && !bus_req.arvalid && !busy;
	assign rd_offs = bus_req.araddr[soc_pkg::pad_window_bits-1:0];
	assign wr_offs = bus_req.awaddr[soc_pkg::pad_window_bits-1:0];

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			poll_enable <= 1'b0;
			state_q <= '0;
			rvalid_q <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			if (wr_hs && wr_offs == soc_pkg::pad_ctrl_offs && bus_req.wstrb[0])
				poll_enable <= bus_req.wdata[0];
			if (frame_done)
				state_q <= {pad1_state, pad0_state};
			if (rd_hs)
				rvalid_q <= 1'b1;
			else if (bus_req.rready)
				rvalid_q <= 1'b0;
			if (wr_hs)
				bvalid_q <= 1'b1;
			else if (bus_req.bready)
				bvalid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_hs) begin
			rdata_q <= '0;
			rresp_q <= soc_pkg::resp_okay;
			if (rd_offs == soc_pkg::pad_ctrl_offs)
				rdata_q <= {31'd0, poll_enable};
			else if (rd_offs == soc_pkg::pad_state_offs)
				rdata_q <= {16'd0, state_q};
			else
				rresp_q <= soc_pkg::resp_slverr;
		end
		// Only pad_ctrl takes writes
		if (wr_hs)
			bresp_q <= (wr_offs == soc_pkg::pad_ctrl_offs) ? soc_pkg::resp_okay : soc_pkg::resp_slverr;
	end

	assign bus_rsp = '{
		awready: wr_hs,
		wready: wr_hs,
		bvalid: bvalid_q,
		bresp: bresp_q,
		arready: !busy,
		rvalid: rvalid_q,
		rdata: rdata_q,
		rresp: rresp_q
	};

endmodule

// ==== rtl/soc_bus_top.sv ====
// Bus subsystem top level: the external AXI-lite master port feeds the decoder and its three slaves
`timescale 1ns/100ps

module soc_bus_top #(
	parameter int boot_words = 1024,
	parameter int pad_div = 256
) (
	input logic clk_50mhz,
	input logic resetn,
	input soc_pkg::axil_req_t host_req,
	output soc_pkg::axil_rsp_t host_rsp,
	output logic pad_latch,
	output logic pad_clk,
	input logic pad0_data,
	input logic pad1_data
);

	soc_pkg::axil_req_t boot_req;
	soc_pkg::axil_rsp_t boot_rsp;
	soc_pkg::axil_req_t pad_req;
	soc_pkg::axil_rsp_t pad_rsp;
	soc_pkg::axil_req_t counter_req;
	soc_pkg::axil_rsp_t counter_rsp;

	logic poll_enable;
	logic frame_done;
	soc_pkg::buttons_t pad0_state;
	soc_pkg::buttons_t pad1_state;

	axil_decoder i_decoder (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.up_req(host_req),
		.up_rsp(host_rsp),
		.boot_req(boot_req),
		.boot_rsp(boot_rsp),
		.pad_req(pad_req),
		.pad_rsp(pad_rsp),
		.counter_req(counter_req),
		.counter_rsp(counter_rsp)
	);

	boot_ram #(.boot_words(boot_words)) i_boot_ram (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus_req(boot_req),
		.bus_rsp(boot_rsp)
	);

	tick_counter i_tick_counter (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus_req(counter_req),
		.bus_rsp(counter_rsp)
	);

	pad_regs i_pad_regs (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.bus_req(pad_req),
		.bus_rsp(pad_rsp),
		.poll_enable(poll_enable),
		.pad0_state(pad0_state),
		.pad1_state(pad1_state),
		.frame_done(frame_done)
	);

	pad_reader #(.pad_div(pad_div)) i_pad_reader (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.poll_enable(poll_enable),
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data),
		.pad0_state(pad0_state),
		.pad1_state(pad1_state),
		.frame_done(frame_done)
	);

endmodule

// ==== testbench/pad_model.sv ====
// Behavioral serial game pad for the testbench, shifts out a fixed button byte on latch and clock
`timescale 1ns/100ps

module pad_model #(
	parameter logic [7:0] buttons = 8'h00
) (
	input logic pad_latch,
	input logic pad_clk,
	output logic pad_data
);

	logic [7:0] shift_q;

	initial begin
		shift_q = 8'h00;
	end

	// Latch loads the buttons, each pad_clk rise moves to the next one
	always @(posedge pad_latch or posedge pad_clk) begin
		if (pad_latch)
			shift_q <= buttons;
		else
			shift_q <= {1'b0, shift_q[7:1]};
	end

	// Active low on the wire
	assign pad_data = ~shift_q[0];

endmodule

// ==== testbench/tb_soc_bus_top.sv ====
// Simulation top that runs a table of bus transactions through the soc_bus_top host port
`timescale 1ns/100ps

module tb_soc_bus_top;

	localparam int pad_div = 4;
	localparam int boot_words = 1024;
	// Latch tick plus sixteen clock half periods and one spare tick
	localparam int frame_cycles = 18 * pad_div;
	localparam soc_pkg::addr_t boot_a = soc_pkg::boot_base;
	localparam soc_pkg::addr_t wrap_bytes = boot_words * 4;
	localparam soc_pkg::addr_t pad_a = soc_pkg::pad_base;
	localparam soc_pkg::addr_t cnt_a = soc_pkg::counter_base;
	localparam soc_pkg::resp_t okay = soc_pkg::resp_okay;
	localparam soc_pkg::resp_t slv = soc_pkg::resp_slverr;
	localparam soc_pkg::resp_t dec = soc_pkg::resp_decerr;

	typedef enum logic [2:0] {op_read, op_write, op_lo_pair, op_pins_idle, op_wait_frames} op_t;

	typedef struct packed {
		logic [127:0] name;
		op_t op;
		soc_pkg::addr_t addr;
		soc_pkg::data_t wdata;
		soc_pkg::strb_t wstrb;
		soc_pkg::data_t exp_data;
		soc_pkg::resp_t exp_resp;
		logic [3:0] stall;
	} entry_t;

	logic clk_50mhz;
	logic resetn;
	soc_pkg::axil_req_t host_req;
	soc_pkg::axil_rsp_t host_rsp;
	logic pad_latch;
	logic pad_clk;
	logic pad0_data;
	logic pad1_data;
	int cycle_count = 0;
	entry_t stim[$];

	soc_bus_top #(.boot_words(boot_words), .pad_div(pad_div)) i_soc_bus_top (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.host_req(host_req),
		.host_rsp(host_rsp),
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data)
	);

	pad_model #(.buttons(8'hA5)) i_pad0 (
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.pad_data(pad0_data)
	);
	pad_model #(.buttons(8'h3C)) i_pad1 (
		.pad_latch(pad_latch),
		.pad_clk(pad_clk),
		.pad_data(pad1_data)
	);

	always #10 clk_50mhz = ~clk_50mhz;

	always @(posedge clk_50mhz) begin
		cycle_count <= cycle_count + 1;
	end

	function automatic entry_t make_entry(input logic [127:0] name, input op_t op,
		input soc_pkg::addr_t addr, input soc_pkg::data_t wdata, input soc_pkg::strb_t wstrb,
		input soc_pkg::data_t exp_data, input soc_pkg::resp_t exp_resp, input logic [3:0] stall);
		return '{name, op, addr, wdata, wstrb, exp_data, exp_resp, stall};
	endfunction

	task automatic check_value(input logic [127:0] name, input soc_pkg::data_t expected,
		input soc_pkg::data_t actual);
		assert (actual === expected) else begin
			$display("** Error %0s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	// Hands back the cycle count at the address handshake
	// rready stays low for the first stall cycles of rvalid
	task automatic bus_read(input logic [127:0] name, input soc_pkg::addr_t addr, input int stall,
		output soc_pkg::data_t data, output soc_pkg::resp_t resp, output int hs_cycle);
		logic hs;
		soc_pkg::data_t held;
		host_req.arvalid = 1'b1;
		host_req.araddr = addr;
		host_req.rready = (stall == 0);
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk_50mhz);
			hs = host_rsp.arready;
			hs_cycle = cycle_count;
			@(posedge clk_50mhz);
			#1;
		end
		host_req.arvalid = 1'b0;
		do @(negedge clk_50mhz); while (!host_rsp.rvalid);
		if (stall > 0) begin
			held = host_rsp.rdata;
			repeat (stall) begin
				@(posedge clk_50mhz);
				#1;
				@(negedge clk_50mhz);
				check_value(name, 32'd1, 32'(host_rsp.rvalid));
				check_value(name, held, host_rsp.rdata);
			end
			@(posedge clk_50mhz);
			#1;
			host_req.rready = 1'b1;
			@(negedge clk_50mhz);
		end
		data = host_rsp.rdata;
		resp = host_rsp.rresp;
		@(posedge clk_50mhz);
		#1;
		host_req.rready = 1'b0;
	endtask

	task automatic bus_write(input soc_pkg::addr_t addr, input soc_pkg::data_t data,
		input soc_pkg::strb_t strb, output soc_pkg::resp_t resp);
		logic hs;
		host_req.awvalid = 1'b1;
		host_req.wvalid = 1'b1;
		host_req.awaddr = addr;
		host_req.wdata = data;
		host_req.wstrb = strb;
		host_req.bready = 1'b1;
		hs = 1'b0;
		while (!hs) begin
			@(negedge clk_50mhz);
			hs = host_rsp.awready && host_rsp.wready;
			@(posedge clk_50mhz);
			#1;
		end
		host_req.awvalid = 1'b0;
		host_req.wvalid = 1'b0;
		do @(negedge clk_50mhz); while (!host_rsp.bvalid);
		resp = host_rsp.bresp;
		@(posedge clk_50mhz);
		#1;
		host_req.bready = 1'b0;
	endtask

	task automatic run_entry(input entry_t e);
		soc_pkg::data_t data;
		soc_pkg::data_t data2;
		soc_pkg::resp_t resp;
		soc_pkg::resp_t resp2;
		int c1;
		int c2;
		case (e.op)
			op_read: begin
				bus_read(e.name, e.addr, e.stall, data, resp, c1);
				check_value(e.name, e.exp_data, data);
				check_value(e.name, 32'(e.exp_resp), 32'(resp));
			end
			op_write: begin
				bus_write(e.addr, e.wdata, e.wstrb, resp);
				check_value(e.name, 32'(e.exp_resp), 32'(resp));
			end
			op_lo_pair: begin
				bus_read(e.name, e.addr, 0, data, resp, c1);
				bus_read(e.name, e.addr, 0, data2, resp2, c2);
				check_value(e.name, 32'(e.exp_resp), 32'(resp));
				check_value(e.name, 32'(e.exp_resp), 32'(resp2));
				check_value(e.name, c2 - c1, data2 - data);
			end
			op_pins_idle: begin
				repeat (4 * frame_cycles) begin
					@(negedge clk_50mhz);
					check_value(e.name, 32'd0, 32'({pad_latch, pad_clk}));
				end
				@(posedge clk_50mhz);
				#1;
			end
			default: begin
				repeat (2 * frame_cycles) @(posedge clk_50mhz);
				#1;
			end
		endcase
	endtask

	initial begin
		stim.push_back(make_entry("count hi reset", op_read, cnt_a + 4, 0, 0, 0, okay, 0));
		stim.push_back(make_entry("count lo pair", op_lo_pair, cnt_a, 0, 0, 0, okay, 0));
		stim.push_back(make_entry("count wr", op_write, cnt_a, 32'h1234, 4'hf, 0, slv, 0));
		stim.push_back(make_entry("boot wr full", op_write, boot_a, 32'h1122_3344, 4'hf, 0,
			okay, 0));
		stim.push_back(make_entry("boot rd full", op_read, boot_a, 0, 0, 32'h1122_3344, okay, 0));
		stim.push_back(make_entry("boot wr strb 5", op_write, boot_a, 32'hAABB_CCDD, 4'h5, 0,
			okay, 0));
		stim.push_back(make_entry("boot wr strb 8", op_write, boot_a, 32'h9900_0000, 4'h8, 0,
			okay, 0));
		stim.push_back(make_entry("boot rd merged", op_read, boot_a, 0, 0, 32'h99BB_33DD, okay, 0));
		// One memory size past the base lands on the same word
		stim.push_back(make_entry("boot rd wrap", op_read, boot_a + wrap_bytes, 0, 0, 32'h99BB_33DD,
			okay, 0));
		stim.push_back(make_entry("boot wr wrap", op_write, boot_a + wrap_bytes + 8, 32'h0BAD_F00D,
			4'hf, 0, okay, 0));
		stim.push_back(make_entry("boot rd base+8", op_read, boot_a + 8, 0, 0, 32'h0BAD_F00D,
			okay, 0));
		stim.push_back(make_entry("unmapped rd", op_read, 32'h0300_0000, 0, 0, 0, dec, 0));
		stim.push_back(make_entry("unmapped wr", op_write, 32'h0300_0000, 32'h55, 4'hf, 0, dec, 0));
		stim.push_back(make_entry("pad ctrl reset", op_read, pad_a, 0, 0, 0, okay, 0));
		stim.push_back(make_entry("pad pins idle", op_pins_idle, 0, 0, 0, 0, okay, 0));
		stim.push_back(make_entry("pad poll on", op_write, pad_a, 32'h1, 4'hf, 0, okay, 0));
		stim.push_back(make_entry("pad ctrl read", op_read, pad_a, 0, 0, 32'h1, okay, 0));
		stim.push_back(make_entry("pad wait frames", op_wait_frames, 0, 0, 0, 0, okay, 0));
		stim.push_back(make_entry("pad state", op_read, pad_a + 4, 0, 0, 32'h3CA5, okay, 0));
		stim.push_back(make_entry("pad state wr", op_write, pad_a + 4, 32'hFF, 4'hf, 0, slv, 0));
		stim.push_back(make_entry("boot rd stall", op_read, boot_a, 0, 0, 32'h99BB_33DD, okay, 5));
		stim.push_back(make_entry("boot rd after", op_read, boot_a + 8, 0, 0, 32'h0BAD_F00D,
			okay, 0));

		clk_50mhz = 1'b0;
		resetn = 1'b0;
		host_req = '0;
		repeat (3) @(posedge clk_50mhz);
		#1;
		resetn = 1'b1;
		foreach (stim[i])
			run_entry(stim[i]);
		$display("TESTBENCH PASSED");
		$finish;
	end

	// Watchdog sized from the table and the pad frames
	initial begin
		longint limit;
		#1;
		limit = (longint'(stim.size()) * 64 + 40 * frame_cycles + 10) * 20;
		#(limit);
		$display("Timeout: the tests did not finish in the allowed time");
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

endmodule

// ==== filelist.f ====
rtl/soc_pkg.sv
rtl/axil_decoder.sv
rtl/boot_ram.sv
rtl/tick_counter.sv
rtl/pad_reader.sv
rtl/pad_regs.sv
rtl/soc_bus_top.sv
testbench/pad_model.sv
testbench/tb_soc_bus_top.sv
